//--- tests/ntt_pre_cases.txt
# seed     wgap reads rgap mclr
# wgap, rgap: 0 back-to-back, 1 random idle cycles; mclr 1 clears halfway through the load
00000001   0    64    0    0
0000a5a5   1    64    0    0
13579bdf   0    65    0    0
2468ace0   1    65    1    0
deadbeef   0    128   0    0
0badf00d   1    128   1    0
00c0ffee   0    64    1    1
7f3e2d1c   1    70    0    1
11223344   0    16    0    0
55667788   1    1     1    0
99aabbcc   0    200   0    0
ddeeff00   1    200   1    1
cafe0123   0    63    1    0
fedcba98   1    96    0    0
31415926   0    130   1    1
27182818   1    64    1    1
0000ffff   0    192   1    0
ffff0000   1    33    0    1
12345678   0    256   0    0
87654321   1    100   1    0
a1b2c3d4   0    48    0    1
5a5a5a5a   1    80    1    1

//--- sources.f
src/ntt_pre_pkg.sv
src/coef_loader.sv
src/coef_buffer.sv
src/read_sequencer.sv
src/ntt_pre_top.sv
tests/tb_ntt_pre.sv

//--- run.sh
#!/bin/sh
# Builds the ntt_pre testbench with Verilator, runs it and
# decides pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

TOP=tb_ntt_pre
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f sources.f -Mdir "$OBJ" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "FAIL: Verilator build did not succeed"
    exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "FAIL: the testbench reported errors"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

echo "PASS"
exit 0

//--- tests/tb_ntt_pre.sv
module tb_ntt_pre
    import ntt_pre_pkg::*;
();

    localparam int COEF_W       = 12;
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_GAP      = 3;            // Longest random idle stretch
    localparam int EXTRA_WR     = 8;            // Writes offered while full
    localparam int PROBE_RD     = 3;            // Reads offered before any load
    localparam int PASS_READS   = 4 * GROUPS;   // Reads until the order wraps
    localparam int MAX_CASES    = 32;
    localparam int VAL_W        = LANES * COEF_W;
    localparam logic [31:0] SEED = 32'hbca3_5926;

    logic                         clk;
    logic                         rst;
    logic                         clear;
    logic                         wr;
    logic [COEF_W-1:0]            x;
    logic [COEF_W-1:0]            y;
    logic                         rd;
    logic                         full;
    logic [LANES-1:0][COEF_W-1:0] lanes;
    logic                         out_valid;
    seg_t                         out_seg;

    // Case table from the cases file
    logic [31:0] case_seed [MAX_CASES];
    int          case_wgap [MAX_CASES];
    int          case_reads [MAX_CASES];
    int          case_rgap [MAX_CASES];
    int          case_mclr [MAX_CASES];
    int          n_cases;
    logic        cases_loaded;

    // Reference model state
    logic [COEF_W-1:0]            m_f [N_COEF];
    logic [COEF_W-1:0]            m_g [N_COEF];
    int                           m_wcnt;
    logic                         m_full;
    int                           m_rd_count;
    logic                         valid_due;      // Read accepted at the last edge
    logic [LANES-1:0][COEF_W-1:0] exp_lanes_q [$];
    logic [1:0]                   exp_seg_q [$];
    logic [31:0]                  rng_state;

    ntt_pre_top #(
        .COEF_W (COEF_W)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .wr        (wr),
        .x         (x),
        .y         (y),
        .rd        (rd),
        .full      (full),
        .lanes     (lanes),
        .out_valid (out_valid),
        .out_seg   (out_seg)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Bit j[b] of the segment position moves to bit dest[b]
    function automatic int permute_pos(input int j);
        int dest [7];
        int p;
        dest = '{6, 5, 0, 4, 3, 2, 1};
        p = 0;
        for (int b = 0; b < 7; b++) begin
            if (((j >> b) & 1) != 0)
                p = p | (1 << dest[b]);
        end
        return p;
    endfunction

    // Lane group of read r in a frame
    function automatic logic [LANES-1:0][COEF_W-1:0] predict_lanes(input int r);
        logic [LANES-1:0][COEF_W-1:0] grp_val;
        int seg;
        int grp;
        int idx;
        seg = r / GROUPS;
        grp = r % GROUPS;
        for (int l = 0; l < LANES; l++) begin
            idx = 2 * permute_pos(grp * LANES + l) + (seg % 2);   // Odd segments take 2p+1
            grp_val[l] = (seg < 2) ? m_f[idx] : m_g[idx];
        end
        return grp_val;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [VAL_W-1:0] expv,
                                   input logic [VAL_W-1:0] actv);
        abort_run($sformatf("ERR %s expected 0x%0h got 0x%0h", name, expv, actv));
    endtask

    // Outputs are stable at the falling edge
    task automatic check_outputs();
        logic [LANES-1:0][COEF_W-1:0] exp_l;
        logic [1:0]                   exp_s;
        assert (full === m_full)
        else report_mismatch("full", VAL_W'(m_full), VAL_W'(full));
        assert (out_valid === valid_due)
        else report_mismatch("out_valid", VAL_W'(valid_due), VAL_W'(out_valid));
        if (valid_due) begin
            exp_l = exp_lanes_q.pop_front();
            exp_s = exp_seg_q.pop_front();
            for (int l = 0; l < LANES; l++) begin
                assert (lanes[l] === exp_l[l])
                else report_mismatch($sformatf("lanes[%0d]", l), VAL_W'(exp_l[l]),
                                     VAL_W'(lanes[l]));
            end
            assert (out_seg === exp_s)
            else report_mismatch("out_seg", VAL_W'(exp_s), VAL_W'(out_seg));
        end
    endtask

    // One clock cycle: check the last edge, then drive and predict the next one
    task automatic drive_cycle(input logic w, input logic [COEF_W-1:0] xv,
                               input logic [COEF_W-1:0] yv, input logic r, input logic c);
        @(negedge clk);
        check_outputs();
        wr    = w;
        x     = xv;
        y     = yv;
        rd    = r;
        clear = c;
        valid_due = r && !c && m_full;
        if (valid_due) begin
            exp_lanes_q.push_back(predict_lanes(m_rd_count));
            exp_seg_q.push_back(2'(m_rd_count / GROUPS));
            m_rd_count = (m_rd_count + 1) % PASS_READS;   // Wraps to f even, group 0
        end
        if (c) begin
            m_wcnt     = 0;
            m_full     = 1'b0;
            m_rd_count = 0;
        end else if (w && !m_full) begin
            m_f[m_wcnt] = xv;
            m_g[m_wcnt] = yv;
            m_wcnt++;
            if (m_wcnt == N_COEF)
                m_full = 1'b1;
        end
    endtask

    task automatic random_pair(output logic [COEF_W-1:0] a, output logic [COEF_W-1:0] b);
        rng_state = xorshift32(rng_state);
        a = rng_state[COEF_W-1:0];
        b = rng_state[2*COEF_W-1:COEF_W];
    endtask

    // Random idle cycles, optionally with stray read strobes
    task automatic idle_gap(input int mode, input logic probe);
        int n;
        if (mode != 0) begin
            rng_state = xorshift32(rng_state);
            n = int'(rng_state % (MAX_GAP + 1));
            repeat (n) drive_cycle(1'b0, '0, '0, probe && rng_state[20], 1'b0);
        end
    endtask

    task automatic load_pairs(input int count, input int mode);
        logic [COEF_W-1:0] a;
        logic [COEF_W-1:0] b;
        for (int k = 0; k < count; k++) begin
            idle_gap(mode, 1'b1);
            random_pair(a, b);
            drive_cycle(1'b1, a, b, 1'b0, 1'b0);
        end
    endtask

    task automatic issue_reads(input int count, input int mode);
        for (int k = 0; k < count; k++) begin
            idle_gap(mode, 1'b0);
            drive_cycle(1'b0, '0, '0, 1'b1, 1'b0);
        end
    endtask

    task automatic run_case(input int i);
        logic [COEF_W-1:0] a;
        logic [COEF_W-1:0] b;
        rng_state = SEED ^ case_seed[i];
        if (rng_state == 32'd0)
            rng_state = SEED;
        $display("Case %0d seed 0x%08h reads %0d", i, case_seed[i], case_reads[i]);
        drive_cycle(1'b0, '0, '0, 1'b1, 1'b1);               // Fresh frame, clear beats rd
        repeat (PROBE_RD) drive_cycle(1'b0, '0, '0, 1'b1, 1'b0);
        if (case_mclr[i] != 0) begin
            load_pairs(HALF_COEF, case_wgap[i]);
            random_pair(a, b);
            drive_cycle(1'b1, a, b, 1'b1, 1'b1);             // Clear beats wr
        end
        load_pairs(N_COEF, case_wgap[i]);
        for (int k = 0; k < EXTRA_WR; k++) begin
            random_pair(a, b);
            drive_cycle(1'b1, a, b, 1'b0, 1'b0);             // Dropped while the frame is full
        end
        issue_reads(case_reads[i], case_rgap[i]);
        repeat (2) drive_cycle(1'b0, '0, '0, 1'b0, 1'b0);    // Let the last group show
    endtask

    initial begin : watchdog
        longint budget;
        wait (cases_loaded);
        budget = RESET_CYCLES + 200;
        for (int i = 0; i < n_cases; i++) begin
            budget += (((case_mclr[i] != 0) ? HALF_COEF + 1 : 0) + N_COEF + EXTRA_WR
                       + PROBE_RD + 3 + case_reads[i]) * (MAX_GAP + 1);
        end
        #(budget * PERIOD);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        int          fd;
        int          code;
        int          n;
        string       line;
        logic [31:0] s;
        int          wg;
        int          nr;
        int          rg;
        int          mc;
        rst        = 1'b1;
        clear      = 1'b0;
        wr         = 1'b0;
        x          = '0;
        y          = '0;
        rd         = 1'b0;
        m_wcnt     = 0;
        m_full     = 1'b0;
        m_rd_count = 0;
        valid_due  = 1'b0;
        rng_state  = SEED;
        n_cases    = 0;
        cases_loaded = 1'b0;

        fd = $fopen("tests/ntt_pre_cases.txt", "r");
        assert (fd != 0) else abort_run("Cannot open tests/ntt_pre_cases.txt");
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            code = $fgets(line, fd);
            n = $sscanf(line, "%h %d %d %d %d", s, wg, nr, rg, mc);
            if (code != 0 && n == 5) begin                   // Comment lines do not scan
                case_seed[n_cases]  = s;
                case_wgap[n_cases]  = wg;
                case_reads[n_cases] = nr;
                case_rgap[n_cases]  = rg;
                case_mclr[n_cases]  = mc;
                n_cases++;
            end
        end
        $fclose(fd);
        assert (n_cases > 0) else abort_run("The cases file holds no test case");
        cases_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_cases; i++)
            run_case(i);

        $display("No errors");
        $finish;
    end

endmodule

//--- src/ntt_pre_top.sv
module ntt_pre_top
    import ntt_pre_pkg::*;
#(
    parameter int COEF_W = 12
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         clear,
    input  logic                         wr,
    input  logic [COEF_W-1:0]            x,
    input  logic [COEF_W-1:0]            y,
    input  logic                         rd,
    output logic                         full,
    output logic [LANES-1:0][COEF_W-1:0] lanes,
    output logic                         out_valid,
    output seg_t                         out_seg
);

    // Write side
    logic             we;
    logic [IDX_W-1:0] waddr;

    // Read side
    logic                        re;
    logic                        rsel_g;
    logic [LANES-1:0][IDX_W-1:0] raddr;

    // Fills f and g, one pair per accepted strobe
    coef_loader u_loader (
        .clk   (clk),
        .rst   (rst),
        .clear (clear),
        .wr    (wr),
        .we    (we),
        .waddr (waddr),
        .full  (full)
    );

    coef_buffer #(
        .COEF_W (COEF_W)
    ) u_buffer (
        .clk    (clk),
        .we     (we),
        .waddr  (waddr),
        .x      (x),
        .y      (y),
        .re     (re),
        .rsel_g (rsel_g),
        .raddr  (raddr),
        .lanes  (lanes)
    );

    // Serves the four segments in forward transform order
    read_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .rd        (rd),
        .full      (full),
        .re        (re),
        .rsel_g    (rsel_g),
        .raddr     (raddr),
        .out_valid (out_valid),
        .out_seg   (out_seg)
    );

endmodule

//--- src/read_sequencer.sv
module read_sequencer
    import ntt_pre_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        rd,
    input  logic                        full,
    output logic                        re,
    output logic                        rsel_g,
    output logic [LANES-1:0][IDX_W-1:0] raddr,
    output logic                        out_valid,
    output seg_t                        out_seg
);

    localparam int GRP_W  = $clog2(GROUPS);
    localparam int LANE_W = $clog2(LANES);

    seg_t             seg;       // Segment of the next read
    logic [GRP_W-1:0] grp;       // Group inside that segment
    logic             odd;       // Odd half-sequence of f or g
    logic             grp_last;

    // Reads only count once both polynomials are loaded
    assign re       = rd && !clear && full;
    assign grp_last = (grp == GRP_W'(GROUPS - 1));

    assign rsel_g = (seg == SEG_G_EVEN) || (seg == SEG_G_ODD);
    assign odd    = (seg == SEG_F_ODD) || (seg == SEG_G_ODD);

    // Segment and group counters, 64 reads per full pass
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg <= SEG_F_EVEN;
            grp <= '0;
        end else if (clear) begin
            seg <= SEG_F_EVEN;
            grp <= '0;
        end else if (re) begin
            grp <= grp + 1'b1;
            if (grp_last)
                seg <= next_seg(seg);   // Wraps back to f even after g odd
        end
    end

    // Lane l reads position grp*8 + l of the segment.
    // The permuted position p selects coefficient 2p or 2p+1.
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            raddr[l] = {perm_index({grp, LANE_W'(l)}), odd};
        end
    end

    // Aligned with the registered lanes of the buffer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_seg   <= SEG_F_EVEN;
        end else begin
            out_valid <= re;
            if (re)
                out_seg <= seg;
        end
    end

    // No stall path: each accepted read yields one group next cycle,
    // so a new read can be taken while the previous one is shown

endmodule

//--- src/coef_buffer.sv
module coef_buffer
    import ntt_pre_pkg::*;
#(
    parameter int COEF_W = 12
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [IDX_W-1:0]             waddr,
    input  logic [COEF_W-1:0]            x,
    input  logic [COEF_W-1:0]            y,
    input  logic                         re,
    input  logic                         rsel_g,
    input  logic [LANES-1:0][IDX_W-1:0]  raddr,
    output logic [LANES-1:0][COEF_W-1:0] lanes
);

    // Polynomial storage, one entry per coefficient
    logic [COEF_W-1:0] f_mem [N_COEF];
    logic [COEF_W-1:0] g_mem [N_COEF];

    // Both polynomials take one coefficient per write strobe
    always_ff @(posedge clk) begin
        if (we) begin
            f_mem[waddr] <= x;
            g_mem[waddr] <= y;
        end
    end

    // Eight independent read ports.
    // The sequencer only reads once the frame is full, so reads
    // and writes never touch the memories in the same cycle.
    always_ff @(posedge clk) begin
        if (re) begin
            for (int l = 0; l < LANES; l++) begin
                if (rsel_g)
                    lanes[l] <= g_mem[raddr[l]];   // Segments g even, g odd
                else
                    lanes[l] <= f_mem[raddr[l]];   // Segments f even, f odd
            end
        end
    end

    // Lanes hold the last group between reads

endmodule

//--- src/coef_loader.sv
module coef_loader
    import ntt_pre_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic             wr,
    output logic             we,
    output logic [IDX_W-1:0] waddr,
    output logic             full
);

    logic [IDX_W-1:0] idx;    // Next free slot in f and g
    logic             last;   // Current write fills the final slot

    // Clear has priority, full blocks further writes
    assign we    = wr && !clear && !full;
    assign waddr = idx;
    assign last  = (idx == IDX_W'(N_COEF - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx  <= '0;
            full <= 1'b0;
        end else if (clear) begin
            idx  <= '0;
            full <= 1'b0;
        end else if (we) begin
            idx <= idx + 1'b1;   // Wraps to 0 after the last slot
            if (last)
                full <= 1'b1;
        end
    end

    // Frame stays full until cleared; the index is back at zero
    // by then, so a restart after clear loads from slot 0 again.
    //
    // Writes that arrive while full are dropped here and never
    // reach the memories.

endmodule

//--- src/ntt_pre_pkg.sv
package ntt_pre_pkg;

    // Polynomial and readout geometry
    localparam int N_COEF    = 256;          // Coefficients per polynomial
    localparam int HALF_COEF = N_COEF / 2;   // One even or odd segment
    localparam int LANES     = 8;            // Coefficients per read
    localparam int GROUPS    = HALF_COEF / LANES;
    localparam int IDX_W     = $clog2(N_COEF);

    // Position inside an even or odd half-sequence
    localparam int POS_W = $clog2(HALF_COEF);

    // Readout segments, listed in the order they are served
    typedef enum logic [1:0] {
        SEG_F_EVEN = 2'd0,
        SEG_F_ODD  = 2'd1,
        SEG_G_EVEN = 2'd2,
        SEG_G_ODD  = 2'd3
    } seg_t;

    // Maps the read position j inside a segment to the position p
    // in the half-sequence, as the forward butterflies expect it.
    // Lane bits 0 and 1 pick the quarter, bit 2 picks the neighbour,
    // the group bits come out reversed.
    function automatic logic [POS_W-1:0] perm_index(input logic [POS_W-1:0] j);
        logic [POS_W-1:0] p;
        p[6] = j[0];
        p[5] = j[1];
        p[0] = j[2];
        p[4] = j[3];
        p[3] = j[4];
        p[2] = j[5];
        p[1] = j[6];
        return p;
    endfunction

    // Next segment in readout order, wraps after g odd
    function automatic seg_t next_seg(input seg_t s);
        seg_t n;
        case (s)
            SEG_F_EVEN: n = SEG_F_ODD;
            SEG_F_ODD:  n = SEG_G_EVEN;
            SEG_G_EVEN: n = SEG_G_ODD;
            default:    n = SEG_F_EVEN;
        endcase
        return n;
    endfunction

endpackage
